// ==== Makefile ====
# Verilator build and run for the cpu16 core and its testbench.

VERILATOR ?= verilator
TOP       ?= cpu16_tb
SRCS      ?= -f cpu16.f
VFLAGS    ?= --timing --assert
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) $(SRCS)

$(OBJDIR)/V$(TOP): $(shell cat cpu16.f)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) $(SRCS)

sim: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJDIR)

// ==== cpu16.f ====
source/cpuPkg.sv
source/fetchUnit.sv
source/registerFile.sv
source/decodeUnit.sv
source/executeUnit.sv
source/memoryUnit.sv
source/cpu16.sv
tests/cpu16_assertions.sv
tests/cpu16_tb.sv

// ==== source/cpu16.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu16 #(
	parameter cpuPkg::dataT resetPc = 16'h0000
) (
	input wire logic clk,
	input wire logic rstN,
	output cpuPkg::dataT instrAddr,
	input wire cpuPkg::dataT instr,
	output cpuPkg::wbMasterT wbOut,
	input wire logic wbAck,
	input wire cpuPkg::dataT wbDatIn,
	output cpuPkg::dataT pc,
	output logic hlt
);

	cpuPkg::dataT fetchPc, fetchInstr, fetchPcNext, target, wrData;
	logic fetchValid, stall, halting, redirect, memBusy, wrEn;
	cpuPkg::regAddrT wrAddr;
	cpuPkg::idExT idEx;
	cpuPkg::exMemT exMem;

	// the instruction port is a plain combinational read at the pc.
	assign instrAddr = fetchPc;
	assign pc = fetchPc;

	fetchUnit #(.resetPc(resetPc)) fetch0 (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.stall(stall),
		.memBusy(memBusy),
		.halting(halting),
		.redirect(redirect),
		.target(target),
		.pc(fetchPc),
		.fetchInstr(fetchInstr),
		.fetchPcNext(fetchPcNext),
		.fetchValid(fetchValid)
	);

	decodeUnit decode0 (
		.clk(clk),
		.rstN(rstN),
		.fetchInstr(fetchInstr),
		.fetchPcNext(fetchPcNext),
		.fetchValid(fetchValid),
		.flush(redirect), // taken transfer kills the word in decode.
		.memBusy(memBusy),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.stall(stall),
		.halting(halting),
		.idEx(idEx)
	);

	executeUnit execute0 (
		.clk(clk),
		.rstN(rstN),
		.idEx(idEx),
		.memBusy(memBusy),
		.redirect(redirect),
		.target(target),
		.exMem(exMem)
	);

	memoryUnit memory0 (
		.clk(clk),
		.rstN(rstN),
		.exMem(exMem),
		.wbOut(wbOut),
		.wbAck(wbAck),
		.wbDatIn(wbDatIn),
		.memBusy(memBusy),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.hlt(hlt)
	);

endmodule

`default_nettype wire

// ==== source/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	typedef logic [15:0] dataT;
	typedef logic [3:0] regAddrT;
	typedef logic [3:0] opcodeT;
	typedef logic [2:0] condT;
	typedef logic [2:0] aluOpT;

	//////////////////////////////////////////////////
	// opcodes, bits 15:12 of the instruction.
	localparam opcodeT opAdd = 4'h0;
	localparam opcodeT opSub = 4'h1;
	localparam opcodeT opAnd = 4'h2;
	localparam opcodeT opNor = 4'h3;
	localparam opcodeT opSll = 4'h4;
	localparam opcodeT opSrl = 4'h5;
	localparam opcodeT opSra = 4'h6;
	localparam opcodeT opLw  = 4'h8;
	localparam opcodeT opSw  = 4'h9;
	localparam opcodeT opLhb = 4'hA;
	localparam opcodeT opLlb = 4'hB;
	localparam opcodeT opB   = 4'hC;
	localparam opcodeT opJal = 4'hD;
	localparam opcodeT opJr  = 4'hE;
	localparam opcodeT opHlt = 4'hF;

	// branch conditions, bits 11:9.
	localparam condT NEQ    = 3'd0;
	localparam condT EQ     = 3'd1;
	localparam condT GT     = 3'd2;
	localparam condT LT     = 3'd3;
	localparam condT GTE    = 3'd4;
	localparam condT LTE    = 3'd5;
	localparam condT OVFL   = 3'd6;
	localparam condT UNCOND = 3'd7;

	localparam aluOpT ADD  = 3'd0;
	localparam aluOpT SUB  = 3'd1;
	localparam aluOpT AND  = 3'd2;
	localparam aluOpT NOR  = 3'd3;
	localparam aluOpT SLL  = 3'd4;
	localparam aluOpT SRL  = 3'd5;
	localparam aluOpT SRA  = 3'd6;
	localparam aluOpT PASS = 3'd7; // llb, lhb and the jal link.

	//////////////////////////////////////////////////
	typedef struct packed {
		logic valid;
		opcodeT opcode;
		dataT opA;
		dataT opB;
		dataT imm;
		regAddrT dest;
		logic regWe;
		logic memRd;
		logic memWr;
		condT cond;
		logic halt;
		dataT pcNext;
	} idExT;

	typedef struct packed {
		logic valid;
		dataT result; // alu result or memory address.
		dataT storeData;
		regAddrT dest;
		logic regWe;
		logic memRd;
		logic memWr;
		logic halt;
	} exMemT;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		dataT adr;
		dataT dat;
	} wbMasterT;

endpackage

`default_nettype wire

// ==== source/decodeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeUnit (
	input wire logic clk,
	input wire logic rstN,
	input wire cpuPkg::dataT fetchInstr,
	input wire cpuPkg::dataT fetchPcNext,
	input wire logic fetchValid,
	input wire logic flush,
	input wire logic memBusy,
	input wire logic wrEn,
	input wire cpuPkg::regAddrT wrAddr,
	input wire cpuPkg::dataT wrData,
	output logic stall,
	output logic halting,
	output cpuPkg::idExT idEx
);

	cpuPkg::opcodeT opcode;
	cpuPkg::regAddrT rd, rs, rt, srcB;
	logic [3:0] memOffset;
	logic [7:0] byteImm;
	logic [8:0] branchOffset;
	logic [11:0] jumpOffset;
	cpuPkg::dataT rsData, rtData;
	logic usesA, usesB;
	cpuPkg::idExT idExNext;

	//////////////////////////////////////////////////
	// instruction fields.
	assign opcode = fetchInstr[15:12];
	assign rd = fetchInstr[11:8];
	assign rs = fetchInstr[7:4];
	assign rt = fetchInstr[3:0];
	assign memOffset = fetchInstr[3:0];
	assign byteImm = fetchInstr[7:0];
	assign branchOffset = fetchInstr[8:0];
	assign jumpOffset = fetchInstr[11:0];

	// sw reads its data register and lhb its own rd through the second port.
	assign srcB = (opcode == cpuPkg::opSw || opcode == cpuPkg::opLhb) ? rd : rt;

	registerFile regFile0 (
		.clk(clk),
		.rstN(rstN),
		.rsAddr(rs),
		.rtAddr(srcB),
		.rsData(rsData),
		.rtData(rtData),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	always_comb
	begin
		idExNext = '0;
		usesA = 1'b0;
		usesB = 1'b0;
		idExNext.valid = 1'b1;
		idExNext.opcode = opcode;
		idExNext.opA = rsData;
		idExNext.opB = rtData;
		idExNext.dest = rd;
		idExNext.cond = fetchInstr[11:9];
		idExNext.pcNext = fetchPcNext;
		case (opcode)
			cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opNor:
			begin
				usesA = 1'b1;
				usesB = 1'b1;
				idExNext.regWe = 1'b1;
			end
			cpuPkg::opSll, cpuPkg::opSrl, cpuPkg::opSra:
			begin
				usesA = 1'b1;
				idExNext.imm = {12'd0, rt}; // shift amount.
				idExNext.regWe = 1'b1;
			end
			cpuPkg::opLw:
			begin
				usesA = 1'b1;
				idExNext.imm = {{12{memOffset[3]}}, memOffset};
				idExNext.regWe = 1'b1;
				idExNext.memRd = 1'b1;
			end
			cpuPkg::opSw:
			begin
				usesA = 1'b1;
				usesB = 1'b1;
				idExNext.imm = {{12{memOffset[3]}}, memOffset};
				idExNext.memWr = 1'b1;
			end
			cpuPkg::opLlb:
			begin
				idExNext.imm = {{8{byteImm[7]}}, byteImm};
				idExNext.regWe = 1'b1;
			end
			cpuPkg::opLhb:
			begin
				usesB = 1'b1;
				idExNext.imm = {8'd0, byteImm};
				idExNext.regWe = 1'b1;
			end
			cpuPkg::opB: idExNext.imm = {{7{branchOffset[8]}}, branchOffset};
			cpuPkg::opJal:
			begin
				idExNext.imm = {{4{jumpOffset[11]}}, jumpOffset};
				idExNext.dest = 4'd15; // link register.
				idExNext.regWe = 1'b1;
			end
			cpuPkg::opJr: usesA = 1'b1;
			cpuPkg::opHlt: idExNext.halt = 1'b1;
			default: ;
		endcase
	end

	// no forwarding. wait one cycle for a producer sitting in execute.
	assign stall = fetchValid && idEx.valid && idEx.regWe && (idEx.dest != 4'd0) &&
		((usesA && rs == idEx.dest) || (usesB && srcB == idEx.dest));
	assign halting = fetchValid && !flush && (opcode == cpuPkg::opHlt);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			idEx <= '0;
		else if (!memBusy)
			idEx <= (fetchValid && !flush && !stall) ? idExNext : '0; // bubble.
	end

endmodule

`default_nettype wire

// ==== source/executeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
	input wire logic clk,
	input wire logic rstN,
	input wire cpuPkg::idExT idEx,
	input wire logic memBusy,
	output logic redirect,
	output cpuPkg::dataT target,
	output cpuPkg::exMemT exMem
);

	cpuPkg::aluOpT aluOp;
	cpuPkg::dataT aluB, aluOut, sum, diff;
	logic ovf, setsAll, setsZero, condMet;
	logic zeroFlag, negFlag, ovfFlag;

	always_comb
	begin
		aluOp = cpuPkg::PASS;
		aluB = idEx.imm;
		setsAll = 1'b0;
		setsZero = 1'b0;
		case (idEx.opcode)
			cpuPkg::opAdd:
			begin
				aluOp = cpuPkg::ADD;
				aluB = idEx.opB;
				setsAll = 1'b1;
			end
			cpuPkg::opSub:
			begin
				aluOp = cpuPkg::SUB;
				aluB = idEx.opB;
				setsAll = 1'b1;
			end
			cpuPkg::opAnd:
			begin
				aluOp = cpuPkg::AND;
				aluB = idEx.opB;
				setsZero = 1'b1;
			end
			cpuPkg::opNor:
			begin
				aluOp = cpuPkg::NOR;
				aluB = idEx.opB;
				setsZero = 1'b1;
			end
			cpuPkg::opSll:
			begin
				aluOp = cpuPkg::SLL;
				setsZero = 1'b1;
			end
			cpuPkg::opSrl:
			begin
				aluOp = cpuPkg::SRL;
				setsZero = 1'b1;
			end
			cpuPkg::opSra:
			begin
				aluOp = cpuPkg::SRA;
				setsZero = 1'b1;
			end
			cpuPkg::opLw, cpuPkg::opSw: aluOp = cpuPkg::ADD; // base plus offset.
			cpuPkg::opLhb: aluB = {idEx.imm[7:0], idEx.opB[7:0]};
			cpuPkg::opJal: aluB = idEx.pcNext;
			default: ;
		endcase
	end

	//////////////////////////////////////////////////
	// alu.
	assign sum = idEx.opA + aluB;
	assign diff = idEx.opA - aluB;

	always_comb
	begin
		ovf = 1'b0;
		case (aluOp)
			cpuPkg::ADD:
			begin
				aluOut = sum;
				ovf = (idEx.opA[15] == aluB[15]) && (sum[15] != idEx.opA[15]);
			end
			cpuPkg::SUB:
			begin
				aluOut = diff;
				ovf = (idEx.opA[15] != aluB[15]) && (diff[15] != idEx.opA[15]);
			end
			cpuPkg::AND: aluOut = idEx.opA & aluB;
			cpuPkg::NOR: aluOut = ~(idEx.opA | aluB);
			cpuPkg::SLL: aluOut = idEx.opA << aluB[3:0];
			cpuPkg::SRL: aluOut = idEx.opA >> aluB[3:0];
			cpuPkg::SRA: aluOut = cpuPkg::dataT'($signed(idEx.opA) >>> aluB[3:0]);
			default: aluOut = aluB;
		endcase
		// arithmetic saturates toward the sign of opA, address math wraps.
		if (ovf && setsAll)
			aluOut = idEx.opA[15] ? 16'h8000 : 16'h7fff;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			zeroFlag <= 1'b0;
			negFlag <= 1'b0;
			ovfFlag <= 1'b0;
		end
		else if (idEx.valid && !memBusy)
		begin
			if (setsAll || setsZero)
				zeroFlag <= (aluOut == 16'h0000);
			if (setsAll)
			begin
				negFlag <= aluOut[15];
				ovfFlag <= ovf;
			end
		end
	end

	//////////////////////////////////////////////////
	// branch and jump resolution.
	always_comb
	begin
		case (idEx.cond)
			cpuPkg::NEQ: condMet = !zeroFlag;
			cpuPkg::EQ: condMet = zeroFlag;
			cpuPkg::GT: condMet = !zeroFlag && !negFlag;
			cpuPkg::LT: condMet = negFlag;
			cpuPkg::GTE: condMet = !negFlag;
			cpuPkg::LTE: condMet = negFlag || zeroFlag;
			cpuPkg::OVFL: condMet = ovfFlag;
			cpuPkg::UNCOND: condMet = 1'b1;
		endcase
	end

	assign redirect = idEx.valid && ((idEx.opcode == cpuPkg::opB && condMet) ||
		idEx.opcode == cpuPkg::opJal || idEx.opcode == cpuPkg::opJr);
	assign target = (idEx.opcode == cpuPkg::opJr) ? idEx.opA : idEx.pcNext + idEx.imm;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			exMem <= '0;
		else if (!memBusy)
		begin
			exMem.valid <= idEx.valid;
			exMem.result <= aluOut;
			exMem.storeData <= idEx.opB;
			exMem.dest <= idEx.dest;
			exMem.regWe <= idEx.valid && idEx.regWe;
			exMem.memRd <= idEx.valid && idEx.memRd;
			exMem.memWr <= idEx.valid && idEx.memWr;
			exMem.halt <= idEx.valid && idEx.halt;
		end
	end

endmodule

`default_nettype wire

// ==== source/fetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchUnit #(
	parameter cpuPkg::dataT resetPc = 16'h0000
) (
	input wire logic clk,
	input wire logic rstN,
	input wire cpuPkg::dataT instr,
	input wire logic stall,
	input wire logic memBusy,
	input wire logic halting,
	input wire logic redirect,
	input wire cpuPkg::dataT target,
	output cpuPkg::dataT pc,
	output cpuPkg::dataT fetchInstr,
	output cpuPkg::dataT fetchPcNext,
	output logic fetchValid
);

	cpuPkg::dataT pcNext;
	logic stopped; // a hlt has left decode, fetch is done for good.

	assign pcNext = pc + 16'd1;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pc <= resetPc;
			fetchValid <= 1'b0;
			stopped <= 1'b0;
		end
		else if (!memBusy)
		begin
			if (redirect)
			begin
				pc <= target;
				fetchValid <= 1'b0; // squash the wrong-path word.
			end
			else if (halting || stopped)
			begin
				stopped <= 1'b1;
				fetchValid <= 1'b0;
			end
			else if (!stall)
			begin
				pc <= pcNext;
				fetchValid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!memBusy && !stall)
		begin
			fetchInstr <= instr;
			fetchPcNext <= pcNext;
		end
	end

endmodule

`default_nettype wire

// ==== source/memoryUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module memoryUnit (
	input wire logic clk,
	input wire logic rstN,
	input wire cpuPkg::exMemT exMem,
	output cpuPkg::wbMasterT wbOut,
	input wire logic wbAck,
	input wire cpuPkg::dataT wbDatIn,
	output logic memBusy,
	output logic wrEn,
	output cpuPkg::regAddrT wrAddr,
	output cpuPkg::dataT wrData,
	output logic hlt
);

	logic busReq;

	// request comes straight from the stage register and is held until ack.
	assign busReq = exMem.valid && (exMem.memRd || exMem.memWr);
	assign memBusy = busReq && !wbAck;

	always_comb
	begin
		wbOut.cyc = busReq;
		wbOut.stb = busReq;
		wbOut.we = busReq && exMem.memWr;
		wbOut.adr = exMem.result; // word address.
		wbOut.dat = exMem.storeData;
	end

	//////////////////////////////////////////////////
	// writeback. a load takes the bus data on the ack edge.
	assign wrEn = exMem.valid && exMem.regWe && !memBusy;
	assign wrAddr = exMem.dest;
	assign wrData = exMem.memRd ? wbDatIn : exMem.result;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			hlt <= 1'b0;
		else if (exMem.valid && exMem.halt)
			hlt <= 1'b1; // sticky until reset.
	end

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input wire logic clk,
	input wire logic rstN,
	input wire cpuPkg::regAddrT rsAddr,
	input wire cpuPkg::regAddrT rtAddr,
	output cpuPkg::dataT rsData,
	output cpuPkg::dataT rtData,
	input wire logic wrEn,
	input wire cpuPkg::regAddrT wrAddr,
	input wire cpuPkg::dataT wrData
);

	cpuPkg::dataT regs [16];
	logic wrLive;

	// r0 never takes a write, so it stays zero after reset.
	assign wrLive = wrEn && (wrAddr != 4'd0);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 16; i++)
				regs[i] <= 16'h0000;
		end
		else if (wrLive)
			regs[wrAddr] <= wrData;
	end

	// write-through. decode sees writeback in the same cycle.
	assign rsData = (wrLive && wrAddr == rsAddr) ? wrData : regs[rsAddr];
	assign rtData = (wrLive && wrAddr == rtAddr) ? wrData : regs[rtAddr];

endmodule

`default_nettype wire

// ==== tests/cpu16_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu16_assertions (
	input wire logic clk,
	input wire logic rstN,
	input wire cpuPkg::wbMasterT wbOut,
	input wire logic wbAck,
	input wire logic hlt
);

	//////////////////////////////////////////////////
	// wishbone classic rules.
	stbNeedsCyc: assert property (@(posedge clk) disable iff (!rstN)
		wbOut.stb |-> wbOut.cyc)
		else $error("stb high without cyc.");

	// a waiting request keeps its address, data and direction.
	requestHeld: assert property (@(posedge clk) disable iff (!rstN)
		(wbOut.stb && !wbAck) |=> (wbOut.stb && $stable(wbOut.adr) &&
		$stable(wbOut.dat) && $stable(wbOut.we)))
		else $error("bus request changed before ack.");

	// halt is sticky and ends all bus traffic.
	hltSticky: assert property (@(posedge clk) disable iff (!rstN)
		hlt |=> hlt)
		else $error("hlt fell without reset.");

	noBusAfterHlt: assert property (@(posedge clk) disable iff (!rstN)
		hlt |-> !wbOut.cyc)
		else $error("bus cycle after hlt.");

endmodule

bind memoryUnit cpu16_assertions asrt0 (
	.clk(clk),
	.rstN(rstN),
	.wbOut(wbOut),
	.wbAck(wbAck),
	.hlt(hlt)
);

`default_nettype wire

// ==== tests/cpu16_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu16_tb;

	localparam int progWords = 44;
	localparam int cycleLimit = 20 * progWords + 100; // generous for wait states.

	logic clk = 1'b0;
	logic rstN = 1'b0;
	logic wbAck = 1'b0;
	cpuPkg::dataT wbDatIn = 16'h0000;
	cpuPkg::dataT instr;
	cpuPkg::dataT instrAddr;
	cpuPkg::dataT pc;
	cpuPkg::wbMasterT wbOut;
	logic hlt;

	cpuPkg::dataT image [0:'h2FF]; // program, data, expected stores, summary.
	cpuPkg::dataT dataMem [0:255];
	logic [31:0] lfsrState = 32'h6180_23a8;
	logic pending = 1'b0;
	logic [1:0] waitLeft = 2'd0;
	logic [1:0] waitPick;
	int errorCount = 0;
	int storeCount = 0;
	int cycleCount = 0;
	cpuPkg::dataT expStoreCount;
	cpuPkg::dataT expHaltPc;

	always #10 clk = ~clk;

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	cpu16 #(.resetPc(16'h0000)) dut0 (
		.clk(clk),
		.rstN(rstN),
		.instrAddr(instrAddr),
		.instr(instr),
		.wbOut(wbOut),
		.wbAck(wbAck),
		.wbDatIn(wbDatIn),
		.pc(pc),
		.hlt(hlt)
	);

	// instruction rom read combinationally.
	assign instr = (instrAddr < 16'h0100) ? image[instrAddr[9:0]] : 16'hF000;

	// 32-bit fibonacci lfsr with taps 32 22 2 1.
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic checkStore(input cpuPkg::dataT adr, input cpuPkg::dataT dat);
		int base;
		base = 'h200 + 2 * storeCount;
		if (storeCount >= int'(expStoreCount))
		begin
			$display("unexpected store of %h to address %h", dat, adr);
			errorCount++;
		end
		else
		begin
			if (adr != image[base])
			begin
				$display("[ERROR] wbOut.adr: got %h expected %h", adr, image[base]);
				errorCount++;
			end
			if (dat != image[base + 1])
			begin
				$display("[ERROR] wbOut.dat: got %h expected %h", dat, image[base + 1]);
				errorCount++;
			end
		end
		storeCount++;
	endtask

	task automatic completeBusCycle();
		wbAck <= 1'b1;
		if (wbOut.we)
		begin
			dataMem[wbOut.adr[7:0]] <= wbOut.dat;
			checkStore(wbOut.adr, wbOut.dat);
		end
		else
			wbDatIn <= dataMem[wbOut.adr[7:0]];
	endtask

	//////////////////////////////////////////////////
	// wishbone slave with 0 to 3 wait states per access.
	always @(posedge clk)
	begin
		if (!rstN)
		begin
			wbAck <= 1'b0;
			pending <= 1'b0;
			waitLeft <= 2'd0;
		end
		else if (wbAck)
			wbAck <= 1'b0; // one-cycle ack.
		else if (wbOut.cyc && wbOut.stb)
		begin
			if (!pending)
			begin
				lfsrState = lfsrStep(lfsrState);
				waitPick[0] = lfsrState[0];
				lfsrState = lfsrStep(lfsrState);
				waitPick[1] = lfsrState[0];
				if (waitPick == 2'd0)
					completeBusCycle();
				else
				begin
					pending <= 1'b1;
					waitLeft <= waitPick - 2'd1;
				end
			end
			else if (waitLeft == 2'd0)
			begin
				pending <= 1'b0;
				completeBusCycle();
			end
			else
				waitLeft <= waitLeft - 2'd1;
		end
	end

	//////////////////////////////////////////////////
	initial
	begin
		for (int i = 0; i <= 'h2FF; i++)
			image[i] = 16'(i) ^ 16'h5A3C;
		$readmemh("tests/cpu16_testdata.hex", image);
		for (int i = 0; i < 256; i++)
			dataMem[i] = image['h100 + i];
		expStoreCount = image['h2F0];
		expHaltPc = image['h2F1];

		repeat (2) @(posedge clk);
		rstN <= 1'b1;

		@(negedge clk);
		if (pc !== 16'h0000)
		begin
			$display("[ERROR] pc: got %h expected %h", pc, 16'h0000);
			errorCount++;
		end
		if (instrAddr !== 16'h0000)
		begin
			$display("[ERROR] instrAddr: got %h expected %h", instrAddr, 16'h0000);
			errorCount++;
		end
		if (hlt !== 1'b0)
		begin
			$display("[ERROR] hlt: got %h expected %h", hlt, 1'b0);
			errorCount++;
		end
		if (wbOut.cyc !== 1'b0)
		begin
			$display("[ERROR] wbOut.cyc: got %h expected %h", wbOut.cyc, 1'b0);
			errorCount++;
		end

		while (!hlt && cycleCount < cycleLimit)
			@(negedge clk);

		if (!hlt)
		begin
			$display("timeout, hlt did not rise within %0d cycles", cycleLimit);
			errorCount++;
		end
		else
		begin
			repeat (10)
			begin
				@(negedge clk);
				if (pc !== expHaltPc)
				begin
					$display("[ERROR] pc: got %h expected %h", pc, expHaltPc);
					errorCount++;
				end
				if (instrAddr !== expHaltPc)
				begin
					$display("[ERROR] instrAddr: got %h expected %h", instrAddr, expHaltPc);
					errorCount++;
				end
			end
			if (storeCount != int'(expStoreCount))
			begin
				$display("[ERROR] store count: got %h expected %h", storeCount, expStoreCount);
				errorCount++;
			end
		end

		$display("errors: %0d, stores: %0d, cycles: %0d", errorCount, storeCount, cycleCount);
		if (errorCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/cpu16_testdata.hex ====
// program words at @000, data memory at @100, expected stores as adr dat at @200,
// store count then halt pc at @2F0.
@000
BD40 // 00 llb r13, 0x40 store base.
8100 // 01 lw r1, r0, 0.
8201 // 02 lw r2, r0, 1.
0312 // 03 add r3, r1, r2 waits on the load.
93D0 // 04 sw r3, r13, 0.
8402 // 05 lw r4, r0, 2.
8502 // 06 lw r5, r0, 2.
0645 // 07 add r6, r4, r5 saturates.
96D1 // 08 sw r6, r13, 1.
1712 // 09 sub r7, r1, r2.
3870 // 0a nor r8, r7, r0.
2982 // 0b and r9, r8, r2.
4A94 // 0c sll r10, r9, 4.
6BA3 // 0d sra r11, r10, 3.
5CA8 // 0e srl r12, r10, 8.
ACAB // 0f lhb r12, 0xab.
97D2 98D3 99D4 9AD5 9BD6 9CD7 // 10-15 store r7 to r12.
1E11 // 16 sub r14, r1, r1 sets zero.
C002 // 17 b neq, not taken.
BE11 // 18 llb r14, 0x11.
9EDF // 19 sw r14, r13, -1.
C202 // 1a b eq, taken.
91DE 91DE // 1b-1c shadow markers.
D003 // 1d jal to 0x21.
91DE 91DE 91DE // 1e-20 shadow markers.
9FDD // 21 sw r15, r13, -3.
BE26 // 22 llb r14, 0x26.
E0E0 // 23 jr r14.
91DE 91DE // 24-25 shadow markers.
1E21 // 26 sub r14, r2, r1 negative.
C601 // 27 b lt, taken.
91DE // 28 shadow marker.
CC01 // 29 b ovfl, not taken.
9EDC // 2a sw r14, r13, -4.
F000 // 2b hlt.
@100
1234 0F0F 7000 8001
@200
0040 2143
0041 7FFF
0042 0325
0043 FCDA
0044 0C0A
0045 C0A0
0046 F814
0047 ABC0
003F 0011
003D 001E
003C FCDB
@2F0
000B 002C
